//--- rtl/dvi_init_pkg.sv
/* DVI transmitter init: I2C command and response types, byte view
   and the register write table for both pixel-clock ranges */

package dvi_init_pkg;

  // --------------------------------------------------
  // Bus engine command and response
  // --------------------------------------------------
  typedef enum logic [1:0] {
    OP_START = 2'd0,
    OP_WRITE = 2'd1,
    OP_STOP  = 2'd2
  } i2c_op_e;

  typedef struct packed {
    i2c_op_e    op;
    logic [7:0] data;
  } i2c_cmd_t;

  // ack is high when the slave held SDA low in the acknowledge slot
  typedef struct packed {
    logic ack;
  } i2c_rsp_t;

  // --------------------------------------------------
  // Byte on the wire
  // --------------------------------------------------
  typedef struct packed {
    logic [6:0] dev_addr;
    logic       rw;
  } i2c_addr_byte_t;

  // First byte of a frame is address plus direction, later ones are raw data
  typedef union packed {
    logic [7:0]     raw;
    i2c_addr_byte_t addr;
  } i2c_byte_u;

  localparam logic I2C_WRITE = 1'b0;

  // --------------------------------------------------
  // Register table
  // --------------------------------------------------
  typedef struct packed {
    logic [7:0] reg_addr;
    logic [7:0] data;
  } reg_write_t;

  localparam int NUM_WRITES = 5;

  // Pixel clock above 65 MHz
  localparam reg_write_t REG_TABLE_FAST [NUM_WRITES] = '{
    '{8'h49, 8'hC0}, '{8'h21, 8'h09}, '{8'h33, 8'h06}, '{8'h34, 8'h26}, '{8'h36, 8'hA0}
  };

  // Pixel clock at or below 65 MHz
  localparam reg_write_t REG_TABLE_SLOW [NUM_WRITES] = '{
    '{8'h49, 8'hC0}, '{8'h21, 8'h09}, '{8'h33, 8'h08}, '{8'h34, 8'h16}, '{8'h36, 8'h60}
  };

endpackage

//--- rtl/i2c_bus_engine.sv
/* I2C master bus engine: turns start, write-byte and stop commands
   into open-drain SCL/SDA timing and returns the slave acknowledge */

`timescale 1ns/10ps

module i2c_bus_engine #(
  parameter int QUARTER_CYCLES = 1500
) (
  input  logic                   clk,
  input  logic                   reset,
  input  dvi_init_pkg::i2c_cmd_t cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output dvi_init_pkg::i2c_rsp_t rsp,
  output logic                   rsp_valid,
  output logic                   scl_oe,
  output logic                   sda_oe,
  input  logic                   sda_in
);

  localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
  localparam logic [QW-1:0] Q_LAST = QW'(QUARTER_CYCLES - 1);

  // Bit phases follow SCL: fall (low), setup (low), rise (high, high)
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_CLK_FALL,
    ST_SETUP,
    ST_CLK_RISE,
    ST_STOP,
    ST_RESP
  } state_e;

  state_e        state;
  logic [QW-1:0] qcnt;
  logic [1:0]    quarter;
  logic [3:0]    bit_cnt;
  logic [8:0]    shift;
  logic          quarter_end;
  logic          first_cycle;
  logic          accept;

  assign quarter_end = (qcnt == Q_LAST);
  assign first_cycle = (qcnt == '0);
  assign cmd_ready   = (state == ST_IDLE);
  assign rsp_valid   = (state == ST_RESP);
  assign accept      = cmd_valid && cmd_ready;

  // --------------------------------------------------
  // Quarter-bit timer
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || state == ST_IDLE || state == ST_RESP || quarter_end) begin
      qcnt <= '0;
    end else begin
      qcnt <= qcnt + QW'(1);
    end
  end

  // --------------------------------------------------
  // Phase FSM and line drivers
  // --------------------------------------------------
  // SCL moves on the edge that enters a phase, so SDA in the fall
  // phase changes one clock after SCL is already low
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      quarter <= '0;
      bit_cnt <= '0;
      scl_oe  <= 1'b0;
      sda_oe  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            quarter <= '0;
            bit_cnt <= '0;
            case (cmd.op)
              dvi_init_pkg::OP_START: begin
                // SDA falls with SCL still high
                sda_oe <= 1'b1;
                state  <= ST_START;
              end
              dvi_init_pkg::OP_WRITE: begin
                scl_oe <= 1'b1;
                state  <= ST_CLK_FALL;
              end
              default: begin
                scl_oe <= 1'b1;
                state  <= ST_STOP;
              end
            endcase
          end
        end

        ST_START: begin
          if (quarter_end) begin
            if (quarter == 2'd1) begin
              quarter <= '0;
              state   <= ST_IDLE;
            end else begin
              scl_oe  <= 1'b1;
              quarter <= quarter + 2'd1;
            end
          end
        end

        ST_CLK_FALL: begin
          if (first_cycle) begin
            sda_oe <= ~shift[8];
          end
          if (quarter_end) begin
            state <= ST_SETUP;
          end
        end

        ST_SETUP: begin
          if (quarter_end) begin
            scl_oe <= 1'b0;
            state  <= ST_CLK_RISE;
          end
        end

        ST_CLK_RISE: begin
          if (quarter_end) begin
            if (quarter == 2'd1) begin
              quarter <= '0;
              bit_cnt <= bit_cnt + 4'd1;
              if (bit_cnt == 4'd8) begin
                state <= ST_RESP;
              end else begin
                scl_oe <= 1'b1;
                state  <= ST_CLK_FALL;
              end
            end else begin
              quarter <= quarter + 2'd1;
            end
          end
        end

        // SCL low and SDA low, then SCL high, then SDA released
        ST_STOP: begin
          if (quarter == 2'd0 && first_cycle) begin
            sda_oe <= 1'b1;
          end
          if (quarter_end) begin
            case (quarter)
              2'd0: scl_oe <= 1'b0;
              2'd1: sda_oe <= 1'b0;
              default: state <= ST_IDLE;
            endcase
            quarter <= (quarter == 2'd2) ? 2'd0 : quarter + 2'd1;
          end
        end

        ST_RESP: state <= ST_IDLE;

        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Shift register and acknowledge capture
  // --------------------------------------------------
  // Trailing 1 releases SDA in the acknowledge slot
  always_ff @(posedge clk) begin
    if (accept) begin
      shift <= {cmd.data, 1'b1};
    end else if (state == ST_CLK_RISE && quarter_end) begin
      // Middle of the high time of the ninth bit
      if (quarter == 2'd0 && bit_cnt == 4'd8) begin
        rsp.ack <= ~sda_in;
      end
      if (quarter == 2'd1) begin
        shift <= {shift[7:0], 1'b1};
      end
    end
  end

endmodule

//--- rtl/dvi_init_sequencer.sv
/* DVI init sequencer: walks the register table, one I2C frame per entry,
   repeats a frame on NACK and raises done when all entries are written */

`timescale 1ns/10ps

module dvi_init_sequencer #(
  parameter logic [6:0] DEV_ADDR = 7'h76
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   pclk_gt_65mhz,
  output dvi_init_pkg::i2c_cmd_t cmd,
  output logic                   cmd_valid,
  input  logic                   cmd_ready,
  input  dvi_init_pkg::i2c_rsp_t rsp,
  input  logic                   rsp_valid,
  output logic                   done
);

  localparam int EW = $clog2(dvi_init_pkg::NUM_WRITES);
  localparam logic [EW-1:0] LAST_ENTRY = EW'(dvi_init_pkg::NUM_WRITES - 1);
  localparam logic [1:0] LAST_BYTE = 2'd2;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_BYTE,
    S_WAIT_ACK,
    S_STOP,
    S_FINISHED
  } state_e;

  state_e                   state;
  logic [EW-1:0]            entry;
  logic [1:0]               byte_idx;
  logic                     mode_fast;
  logic                     nacked;
  dvi_init_pkg::reg_write_t entry_w;
  dvi_init_pkg::i2c_byte_u  tx_byte;

  // --------------------------------------------------
  // Command formation
  // --------------------------------------------------
  always_comb begin
    if (mode_fast) begin
      entry_w = dvi_init_pkg::REG_TABLE_FAST[entry];
    end else begin
      entry_w = dvi_init_pkg::REG_TABLE_SLOW[entry];
    end

    case (byte_idx)
      2'd0: begin
        tx_byte.addr.dev_addr = DEV_ADDR;
        tx_byte.addr.rw       = dvi_init_pkg::I2C_WRITE;
      end
      2'd1:    tx_byte.raw = entry_w.reg_addr;
      default: tx_byte.raw = entry_w.data;
    endcase
  end

  // Data field only matters for write commands
  always_comb begin
    cmd.data = tx_byte.raw;
    case (state)
      S_START: cmd.op = dvi_init_pkg::OP_START;
      S_STOP:  cmd.op = dvi_init_pkg::OP_STOP;
      default: cmd.op = dvi_init_pkg::OP_WRITE;
    endcase
  end

  assign cmd_valid = (state == S_START) || (state == S_BYTE) || (state == S_STOP);

  // High once the engine is idle after the last stop
  assign done = (state == S_FINISHED) && cmd_ready;

  // --------------------------------------------------
  // Frame FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      entry     <= '0;
      byte_idx  <= '0;
      mode_fast <= 1'b0;
      nacked    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: state <= S_START;

        S_START: begin
          if (cmd_ready) begin
            // Pixel clock mode is fixed for the whole frame
            mode_fast <= pclk_gt_65mhz;
            byte_idx  <= '0;
            nacked    <= 1'b0;
            state     <= S_BYTE;
          end
        end

        S_BYTE: begin
          if (cmd_ready) begin
            state <= S_WAIT_ACK;
          end
        end

        S_WAIT_ACK: begin
          if (rsp_valid) begin
            if (!rsp.ack) begin
              // Skip remaining bytes, close the frame, retry same entry
              nacked <= 1'b1;
              state  <= S_STOP;
            end else if (byte_idx == LAST_BYTE) begin
              state <= S_STOP;
            end else begin
              byte_idx <= byte_idx + 2'd1;
              state    <= S_BYTE;
            end
          end
        end

        S_STOP: begin
          if (cmd_ready) begin
            if (nacked) begin
              state <= S_START;
            end else if (entry == LAST_ENTRY) begin
              state <= S_FINISHED;
            end else begin
              entry <= entry + EW'(1);
              state <= S_START;
            end
          end
        end

        S_FINISHED: state <= S_FINISHED;

        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/dvi_init_top.sv
/* DVI init top: register-table sequencer driving the I2C bus engine */

`timescale 1ns/10ps

module dvi_init_top #(
  parameter int         QUARTER_CYCLES = 1500,
  parameter logic [6:0] DEV_ADDR       = 7'h76
) (
  input  logic clk,
  input  logic reset,
  input  logic pclk_gt_65mhz,
  output logic scl_oe,
  output logic sda_oe,
  // Resolved SCL level for bus monitors, no clock stretching here
  input  logic scl_in,
  input  logic sda_in,
  output logic done
);

  dvi_init_pkg::i2c_cmd_t cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;
  dvi_init_pkg::i2c_rsp_t rsp;
  logic                   rsp_valid;

  dvi_init_sequencer #(
    .DEV_ADDR (DEV_ADDR)
  ) u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .pclk_gt_65mhz (pclk_gt_65mhz),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .rsp           (rsp),
    .rsp_valid     (rsp_valid),
    .done          (done)
  );

  i2c_bus_engine #(
    .QUARTER_CYCLES (QUARTER_CYCLES)
  ) u_bus_engine (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .sda_in    (sda_in)
  );

endmodule

//--- bench/i2c_bus_sva.sv
/* I2C bus protocol assertions, bound into the DVI init top */

`timescale 1ns/10ps

module i2c_bus_sva (
  input logic                   clk,
  input logic                   reset,
  input logic                   scl_oe,
  input logic                   sda_oe,
  input logic                   done,
  input dvi_init_pkg::i2c_cmd_t cmd,
  input logic                   cmd_valid,
  input logic                   cmd_ready,
  input logic                   rsp_valid
);

  // High from acceptance of a write-byte command until its response
  logic in_byte;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_byte <= 1'b0;
    end else if (cmd_valid && cmd_ready && cmd.op == dvi_init_pkg::OP_WRITE) begin
      in_byte <= 1'b1;
    end else if (rsp_valid) begin
      in_byte <= 1'b0;
    end
  end

  sda_stable_scl_high: assert property (@(posedge clk)
    in_byte && $changed(sda_oe) |-> scl_oe && $past(scl_oe))
    else $error("SDA changed while SCL high inside a byte");

  bus_released_in_reset: assert property (@(posedge clk)
    reset && $past(reset) |-> !scl_oe && !sda_oe)
    else $error("Bus enables active during reset");

  done_held: assert property (@(posedge clk)
    $fell(done) |-> $past(reset))
    else $error("done fell without reset");

endmodule

bind dvi_init_top i2c_bus_sva u_bus_sva (
  .clk       (clk),
  .reset     (reset),
  .scl_oe    (scl_oe),
  .sda_oe    (sda_oe),
  .done      (done),
  .cmd       (cmd),
  .cmd_valid (cmd_valid),
  .cmd_ready (cmd_ready),
  .rsp_valid (rsp_valid)
);

//--- bench/init_checker.sv
/* Bus monitor for DVI init: decodes I2C frames and checks them
   and done against the register table */

`timescale 1ns/10ps

module init_checker #(
  parameter int         QUARTER_CYCLES = 4,
  parameter logic [6:0] DEV_ADDR       = 7'h76
) (
  input  logic clk,
  input  logic reset,
  input  logic scl_oe,
  input  logic sda_oe,
  input  logic sda_in,
  input  logic pclk_gt_65mhz,
  input  logic done,
  output int   errors,
  output int   frames_ok
);

  localparam int NUM = dvi_init_pkg::NUM_WRITES;

  logic       scl, sda;
  logic       prev_scl, prev_sda, prev_pclk, prev_reset, prev_done;
  logic       in_frame, frame_fast, nacked, have_bit, bit_val;
  logic [3:0] bit_cnt;
  logic [8:0] shift;
  int         byte_cnt;
  int         exp_entry;
  int         done_wait;

  initial begin
    errors    = 0;
    frames_ok = 0;
  end

  task automatic flag_failure(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic value_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
    $display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  // Bits hold the byte MSB first followed by the acknowledge slot
  task automatic check_byte(input logic [8:0] bits);
    dvi_init_pkg::i2c_byte_u  rx;
    dvi_init_pkg::reg_write_t w;
    rx.raw = bits[8:1];
    w = frame_fast ? dvi_init_pkg::REG_TABLE_FAST[exp_entry]
                   : dvi_init_pkg::REG_TABLE_SLOW[exp_entry];
    case (byte_cnt)
      0: begin
        if (rx.addr.dev_addr != DEV_ADDR || rx.addr.rw != 1'b0) begin
          value_mismatch("address byte", {DEV_ADDR, 1'b0}, rx.raw);
        end
      end
      1: if (rx.raw != w.reg_addr) value_mismatch("register address", w.reg_addr, rx.raw);
      default: if (rx.raw != w.data) value_mismatch("register data", w.data, rx.raw);
    endcase
    if (bits[0]) begin
      nacked = 1'b1;
      $display("%0t: entry %0d NACK on byte %0d", $time, exp_entry, byte_cnt);
    end
    byte_cnt++;
  endtask

  // --------------------------------------------------
  // Bus decode and checks
  // --------------------------------------------------
  always @(posedge clk) begin
    scl = !scl_oe;
    sda = sda_in;
    if (reset) begin
      if (prev_reset && (scl_oe || sda_oe || done)) flag_failure("bus or done active in reset");
      in_frame  = 1'b0;
      nacked    = 1'b0;
      have_bit  = 1'b0;
      bit_cnt   = '0;
      byte_cnt  = 0;
      exp_entry = 0;
      done_wait = 0;
    end else begin
      if (prev_scl && scl && prev_sda && !sda) begin
        if (exp_entry == NUM) flag_failure("bus activity after done");
        in_frame   = 1'b1;
        frame_fast = prev_pclk;
        nacked     = 1'b0;
        have_bit   = 1'b0;
        bit_cnt    = '0;
        byte_cnt   = 0;
      end else if (prev_scl && scl && !prev_sda && sda) begin
        have_bit = 1'b0;
        if (!in_frame) begin
          flag_failure("stop without a start");
        end else if (nacked) begin
          $display("%0t: frame for entry %0d closed after NACK", $time, exp_entry);
        end else if (byte_cnt == 3 && bit_cnt == 0) begin
          $display("%0t: entry %0d written (%s)", $time, exp_entry,
                   frame_fast ? "fast" : "slow");
          frames_ok++;
          exp_entry++;
        end else begin
          flag_failure("frame ended before all three bytes");
        end
        in_frame = 1'b0;
      end else if (!prev_scl && scl) begin
        bit_val  = sda;
        have_bit = 1'b1;
        // The slave alone answers in the acknowledge slot
        if (in_frame && bit_cnt == 4'd8 && sda_oe) begin
          flag_failure("master drove SDA in the acknowledge slot");
        end
      end else if (prev_scl && !scl && have_bit) begin
        have_bit = 1'b0;
        if (!in_frame || exp_entry >= NUM) begin
          flag_failure("data bit outside a frame");
        end else if (nacked) begin
          flag_failure("bytes continued after NACK");
        end else begin
          shift   = {shift[7:0], bit_val};
          bit_cnt = bit_cnt + 4'd1;
          if (bit_cnt == 4'd9) begin
            check_byte(shift);
            bit_cnt = '0;
          end
        end
      end

      if (done && exp_entry < NUM) flag_failure("done raised before all entries written");
      if (prev_done && !done) flag_failure("done fell without reset");
      if (exp_entry == NUM && !done) begin
        done_wait++;
        if (done_wait == 4 * QUARTER_CYCLES + 8) flag_failure("done missing after last frame");
      end
    end
    prev_scl   = scl;
    prev_sda   = sda;
    prev_pclk  = pclk_gt_65mhz;
    prev_reset = reset;
    prev_done  = done;
  end

endmodule

//--- bench/tb_dvi_init.sv
/* Testbench for DVI init: clock, reset, random pixel-clock mode and
   an I2C slave that acknowledges or refuses bytes */

`timescale 1ns/10ps

module tb_dvi_init;

  localparam int         QUARTER_CYCLES = 4;
  localparam logic [6:0] DEV_ADDR       = 7'h76;
  localparam int         NUM            = dvi_init_pkg::NUM_WRITES;
  localparam int         MAX_NACKS      = 3;
  localparam int         TIMEOUT_CYCLES = 2 * (NUM + MAX_NACKS) * 40 * 4 * QUARTER_CYCLES * 2;

  logic        clk, reset, pclk_gt_65mhz;
  logic        scl_oe, sda_oe, scl_in, sda_in, done;
  logic        slave_pull, prev_scl, prev_sda;
  logic [31:0] rng;
  logic [3:0]  rise_cnt;
  int          nack_cnt, cycles, errors, frames_ok, test_fails, base;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Open-drain lines, low when anyone pulls
  assign scl_in = !scl_oe;
  assign sda_in = !sda_oe && !slave_pull;

  dvi_init_top #(
    .QUARTER_CYCLES (QUARTER_CYCLES),
    .DEV_ADDR       (DEV_ADDR)
  ) dut (
    .clk           (clk),
    .reset         (reset),
    .pclk_gt_65mhz (pclk_gt_65mhz),
    .scl_oe        (scl_oe),
    .sda_oe        (sda_oe),
    .scl_in        (scl_in),
    .sda_in        (sda_in),
    .done          (done)
  );

  init_checker #(
    .QUARTER_CYCLES (QUARTER_CYCLES),
    .DEV_ADDR       (DEV_ADDR)
  ) u_checker (
    .clk           (clk),
    .reset         (reset),
    .scl_oe        (scl_oe),
    .sda_oe        (sda_oe),
    .sda_in        (sda_in),
    .pclk_gt_65mhz (pclk_gt_65mhz),
    .done          (done),
    .errors        (errors),
    .frames_ok     (frames_ok)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Random pixel-clock mode changes
  always @(posedge clk) begin
    rng <= xorshift(rng);
    if (rng[4:0] == 5'd0) pclk_gt_65mhz <= rng[9];
  end

  // --------------------------------------------------
  // Slave model
  // --------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      rise_cnt   <= '0;
      slave_pull <= 1'b0;
      nack_cnt   <= 0;
    end else if (prev_scl && scl_in && prev_sda && !sda_in) begin
      rise_cnt <= '0;
    end else if (!prev_scl && scl_in) begin
      rise_cnt <= rise_cnt + 4'd1;
    end else if (prev_scl && !scl_in) begin
      if (rise_cnt == 4'd8) begin
        if (rng[2:0] == 3'd0 && nack_cnt < MAX_NACKS) begin
          slave_pull <= 1'b0;
          nack_cnt   <= nack_cnt + 1;
        end else begin
          slave_pull <= 1'b1;
        end
      end else begin
        slave_pull <= 1'b0;
        if (rise_cnt == 4'd9) rise_cnt <= '0;
      end
    end
    prev_scl <= scl_in;
    prev_sda <= sda_in;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: sequence not finished after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    reset         = 1'b1;
    pclk_gt_65mhz = 1'b0;
    rng           = 32'h2eeb;
    slave_pull    = 1'b0;
    prev_scl      = 1'b1;
    prev_sda      = 1'b1;
    cycles        = 0;
    test_fails    = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Test 1 is cut short by a reset inside the third frame
    while (frames_ok < 2) @(negedge clk);
    repeat (300) @(posedge clk);
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    if (done || scl_oe || sda_oe) begin
      $display("test 1: reset did not release the bus and clear done");
      test_fails++;
    end
    $display("test 1 (reset mid-sequence): %0d frames before reset", frames_ok);
    base = frames_ok;
    reset <= 1'b0;

    // Test 2 runs the whole table
    while (!done) @(posedge clk);
    repeat (200) @(negedge clk);
    if (frames_ok - base != NUM) begin
      $display("test 2: expected %0d written frames, saw %0d", NUM, frames_ok - base);
      test_fails++;
    end
    $display("test 2 (full sequence): %0d frames, done %0b", frames_ok - base, done);

    $display("%0d frames checked, %0d checker errors, %0d test failures",
             frames_ok, errors, test_fails);
    if (errors == 0 && test_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
rtl/dvi_init_pkg.sv
rtl/i2c_bus_engine.sv
rtl/dvi_init_sequencer.sv
rtl/dvi_init_top.sv
bench/i2c_bus_sva.sv
bench/init_checker.sv
bench/tb_dvi_init.sv

//--- run.sh
#!/bin/sh
# Build and run the DVI init testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_dvi_init \
  -f list.f \
  -o sim_dvi_init
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_dvi_init > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
